// ==== hdl/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

	// Address geometry.
	// A word address is split into tag and index.
	localparam int addr_w = 14;
	localparam int index_w = 6;
	localparam int tag_w = addr_w - index_w;
	localparam int data_w = 32;
	localparam int num_lines = 1 << index_w;

	typedef logic [addr_w-1:0] addr_t;
	typedef logic [index_w-1:0] index_t;
	typedef logic [tag_w-1:0] tag_t;
	typedef logic [data_w-1:0] data_t;

	// Controller states.
	// The mem states hold a DRAM request open until the acknowledge.
	typedef enum logic [3:0]
	{
		st_idle,
		st_compare,
		st_read_miss,
		st_read_mem,
		st_read_data,
		st_write_hit,
		st_write_miss,
		st_write_mem,
		st_write_data,
		st_write_back
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== hdl/cache_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_controller
(
	input  wire logic clk,
	input  wire logic rst,

	// CPU side.
	input  wire logic cpu_cs,
	input  wire logic cpu_we,
	output logic      cpu_ack,

	// Tag and data stores.
	input  wire logic hit,
	input  wire logic valid,
	input  wire logic dirty,
	output logic      tag_we,
	output logic      dirty_in,
	output logic      clear_dirty,
	output logic      sram_we,
	output logic      sram_data_sel,

	// DRAM side.
	input  wire logic dram_ack,
	output logic      dram_cs,
	output logic      dram_we,
	output logic      write_back
);
	import cache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;

	logic line_hit;

	// A hit needs a valid line as well as a tag match.
	assign line_hit = hit && valid;

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= st_idle;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			st_idle:
			begin
				if (cpu_cs)
					next_state = st_compare;
			end
			st_compare:
			begin
				if (line_hit)
					next_state = cpu_we ? st_write_hit : st_idle;
				else if (valid && dirty)
					next_state = st_write_back;
				else
					next_state = cpu_we ? st_write_miss : st_read_miss;
			end
			st_read_miss, st_read_mem:
			begin
				next_state = dram_ack ? st_read_data : st_read_mem;
			end
			st_read_data:
				next_state = st_idle;
			st_write_miss, st_write_mem:
			begin
				next_state = dram_ack ? st_write_data : st_write_mem;
			end
			st_write_data:
				next_state = st_write_hit;
			st_write_hit:
				next_state = st_idle;
			st_write_back:
			begin
				// Victim is clean after this, so compare now sees a plain miss.
				if (dram_ack)
					next_state = st_compare;
			end
			default:
				next_state = st_idle;
		endcase
	end

	// Strobes decoded from the state.
	always_comb
	begin
		cpu_ack = 1'b0;
		tag_we = 1'b0;
		dirty_in = 1'b0;
		clear_dirty = 1'b0;
		sram_we = 1'b0;
		sram_data_sel = 1'b0;
		dram_cs = 1'b0;
		dram_we = 1'b0;
		write_back = 1'b0;
		case (state)
			st_compare:
				cpu_ack = line_hit && !cpu_we;
			st_read_miss, st_read_mem, st_write_miss, st_write_mem:
				dram_cs = 1'b1;
			st_read_data:
			begin
				// A clean fill whose forwarded word goes straight to the CPU.
				tag_we = 1'b1;
				sram_we = 1'b1;
				sram_data_sel = 1'b1;
				cpu_ack = 1'b1;
			end
			st_write_data:
			begin
				tag_we = 1'b1;
				sram_we = 1'b1;
				sram_data_sel = 1'b1;
			end
			st_write_hit:
			begin
				sram_we = 1'b1;
				dirty_in = 1'b1;
				cpu_ack = 1'b1;
			end
			st_write_back:
			begin
				dram_cs = 1'b1;
				dram_we = 1'b1;
				write_back = 1'b1;
				clear_dirty = dram_ack;
			end
			default:
			begin
			end
		endcase
	end

	// A DRAM request holds until it is acknowledged.
	assert property (@(posedge clk) disable iff (!rst)
		dram_cs && !dram_ack |=> dram_cs && dram_we == $past(dram_we));

	assert property (@(posedge clk) disable iff (!rst)
		cpu_ack |-> cpu_cs);

	// The array is never written while DRAM is busy with this line.
	assert property (@(posedge clk) disable iff (!rst)
		!(sram_we && dram_cs));

endmodule

`default_nettype wire

// ==== hdl/cache_tag_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_tag_store
(
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire cache_pkg::index_t index,
	input  wire cache_pkg::tag_t   tag,
	input  wire logic             tag_we,
	input  wire logic             dirty_in,
	input  wire logic             clear_dirty,
	output logic                  hit,
	output logic                  valid,
	output logic                  dirty,
	output cache_pkg::tag_t       victim_tag
);
	import cache_pkg::*;

	logic [num_lines-1:0] valid_q;
	logic [num_lines-1:0] dirty_q;
	tag_t                 tag_q [num_lines];

	// Status bits.
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			valid_q <= '0;
			dirty_q <= '0;
		end
		else if (tag_we)
		begin
			valid_q[index] <= 1'b1;
			dirty_q[index] <= dirty_in;
		end
		else if (clear_dirty)
		begin
			dirty_q[index] <= 1'b0;
		end
		else if (dirty_in)
		begin
			// Write hit on a line that is already resident.
			dirty_q[index] <= 1'b1;
		end
	end

	// Tag array.
	always_ff @(posedge clk)
	begin
		if (tag_we)
			tag_q[index] <= tag;
	end

	// Lookup at the current index.
	always_comb
	begin
		victim_tag = tag_q[index];
		hit = (tag_q[index] == tag);
		valid = valid_q[index];
		dirty = dirty_q[index];
	end

	// A fill always lands clean, so it can't coincide with a write back.
	assert property (@(posedge clk) disable iff (!rst)
		!(tag_we && clear_dirty));

endmodule

`default_nettype wire

// ==== hdl/cache_data_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_data_store
(
	input  wire logic              clk,
	input  wire cache_pkg::index_t  index,
	input  wire logic              sram_we,
	input  wire logic              sram_data_sel,
	input  wire cache_pkg::data_t   cpu_wdata,
	input  wire cache_pkg::data_t   dram_rdata,
	output cache_pkg::data_t        rdata
);
	import cache_pkg::*;

	data_t mem [num_lines];
	data_t fill_word;
	data_t wr_data;

	// DRAM read data is only valid with the acknowledge.
	// Holding it one cycle lets the fill happen in the following state.
	always_ff @(posedge clk)
	begin
		fill_word <= dram_rdata;
	end

	// The fill multiplexer picks the DRAM word when sram_data_sel is high.
	assign wr_data = sram_data_sel ? fill_word : cpu_wdata;

	always_ff @(posedge clk)
	begin
		if (sram_we)
			mem[index] <= wr_data;
	end

	// Forward the fill word so read data and cpu_ack land together.
	assign rdata = (sram_we && sram_data_sel) ? fill_word : mem[index];

endmodule

`default_nettype wire

// ==== hdl/l1_cache.sv ====
`timescale 1ns/1ns
`default_nettype none

module l1_cache
(
	input  wire logic             clk,
	input  wire logic             rst,

	// CPU port.
	input  wire logic             cpu_cs,
	input  wire logic             cpu_we,
	input  wire cache_pkg::addr_t  cpu_addr,
	input  wire cache_pkg::data_t  cpu_wdata,
	output cache_pkg::data_t       cpu_rdata,
	output logic                  cpu_ack,

	// DRAM port.
	output logic                  dram_cs,
	output logic                  dram_we,
	output cache_pkg::addr_t       dram_addr,
	output cache_pkg::data_t       dram_wdata,
	input  wire cache_pkg::data_t  dram_rdata,
	input  wire logic             dram_ack
);
	import cache_pkg::*;

	index_t index;
	tag_t   tag;
	tag_t   victim_tag;
	tag_t   dram_tag;
	data_t  rdata;

	logic hit;
	logic valid;
	logic dirty;
	logic tag_we;
	logic dirty_in;
	logic clear_dirty;
	logic sram_we;
	logic sram_data_sel;
	logic write_back;

	assign index = cpu_addr[index_w-1:0];
	assign tag = cpu_addr[addr_w-1:index_w];

	// Write back goes to the victim's address, everything else to the CPU's.
	assign dram_tag = write_back ? victim_tag : tag;
	assign dram_addr = {dram_tag, index};
	assign dram_wdata = rdata;
	assign cpu_rdata = rdata;

	cache_controller u_controller
	(
		.clk           (clk),
		.rst           (rst),
		.cpu_cs        (cpu_cs),
		.cpu_we        (cpu_we),
		.cpu_ack       (cpu_ack),
		.hit           (hit),
		.valid         (valid),
		.dirty         (dirty),
		.tag_we        (tag_we),
		.dirty_in      (dirty_in),
		.clear_dirty   (clear_dirty),
		.sram_we       (sram_we),
		.sram_data_sel (sram_data_sel),
		.dram_ack      (dram_ack),
		.dram_cs       (dram_cs),
		.dram_we       (dram_we),
		.write_back    (write_back)
	);

	cache_tag_store u_tag_store
	(
		.clk         (clk),
		.rst         (rst),
		.index       (index),
		.tag         (tag),
		.tag_we      (tag_we),
		.dirty_in    (dirty_in),
		.clear_dirty (clear_dirty),
		.hit         (hit),
		.valid       (valid),
		.dirty       (dirty),
		.victim_tag  (victim_tag)
	);

	cache_data_store u_data_store
	(
		.clk           (clk),
		.index         (index),
		.sram_we       (sram_we),
		.sram_data_sel (sram_data_sel),
		.cpu_wdata     (cpu_wdata),
		.dram_rdata    (dram_rdata),
		.rdata         (rdata)
	);

endmodule

`default_nettype wire

// ==== tests/dram_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module dram_model
(
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             cs,
	input  wire logic             we,
	input  wire cache_pkg::addr_t  addr,
	input  wire cache_pkg::data_t  wdata,
	input  wire logic [2:0]       latency,
	output cache_pkg::data_t       rdata,
	output logic                  ack
);
	import cache_pkg::*;

	data_t mem [1 << addr_w];
	int    wait_count;

	// Preload pattern built from every address bit.
	initial
	begin
		for (int a = 0; a < (1 << addr_w); a++)
			mem[a] = {~a[7:0], a[13:0], a[9:0]};
	end

	always @(posedge clk)
	begin
		if (!rst)
		begin
			ack <= 1'b0;
			wait_count <= 0;
		end
		else if (ack)
		begin
			// One-cycle acknowledge, then ready for the next request.
			ack <= 1'b0;
			wait_count <= 0;
		end
		else if (cs)
		begin
			if (wait_count >= int'(latency))
			begin
				ack <= 1'b1;
				if (we)
					mem[addr] <= wdata;
				else
					rdata <= mem[addr];
			end
			else
				wait_count <= wait_count + 1;
		end
	end

endmodule

`default_nettype wire

// ==== tests/l1_cache_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module l1_cache_tb;
	import cache_pkg::*;

	localparam int period = 100;
	localparam int drive_delay = 10;
	localparam int num_random = 400;
	localparam int num_ops = num_random + 8;

	logic       clk;
	logic       rst;
	logic       cpu_cs;
	logic       cpu_we;
	addr_t      cpu_addr;
	data_t      cpu_wdata;
	data_t      cpu_rdata;
	logic       cpu_ack;
	logic       dram_cs;
	logic       dram_we;
	addr_t      dram_addr;
	data_t      dram_wdata;
	data_t      dram_rdata;
	logic       dram_ack;
	logic [2:0] latency;

	// Last value written to each address, starting from the DRAM preload.
	data_t           shadow [1 << addr_w];
	logic [addr_w:0] dram_log [$];
	logic [31:0]     rng_state;
	int              reads_checked = 0;

	l1_cache UUT (.*);

	dram_model u_dram
	(
		.clk     (clk),
		.rst     (rst),
		.cs      (dram_cs),
		.we      (dram_we),
		.addr    (dram_addr),
		.wdata   (dram_wdata),
		.latency (latency),
		.rdata   (dram_rdata),
		.ack     (dram_ack)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Same pattern the DRAM model starts with.
	function automatic data_t preload_word(input int a);
		return {~a[7:0], a[13:0], a[9:0]};
	endfunction

	function automatic data_t expected_read(input addr_t a);
		return shadow[a];
	endfunction

	task automatic flag_mismatch(input string name, input data_t got, input data_t want);
		$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, want);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped on a mismatch.");
	endtask

	task automatic fail_run(input string what);
		$display("%0t ns: %s", $time, what);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped on a failed check.");
	endtask

	// One CPU request, returning the cycles from request to acknowledge.
	task automatic cpu_access(input logic we, input addr_t addr, input data_t wdata,
		input logic [2:0] lat, output int cycles);
		@(posedge clk);
		#drive_delay;
		cpu_cs = 1'b1;
		cpu_we = we;
		cpu_addr = addr;
		cpu_wdata = wdata;
		latency = lat;
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (!cpu_ack);
		if (we)
			shadow[addr] = wdata;
		@(posedge clk);
		#drive_delay;
		cpu_cs = 1'b0;
		cpu_we = 1'b0;
		@(negedge clk);
		assert (!cpu_ack)
		else fail_run("cpu_ack stayed high for more than one cycle.");
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Read data is checked mid-cycle, where it is stable.
	always @(negedge clk)
	begin
		data_t want;
		if (rst && cpu_ack && cpu_cs && !cpu_we)
		begin
			want = expected_read(cpu_addr);
			assert (cpu_rdata === want)
			else flag_mismatch("cpu_rdata", cpu_rdata, want);
			reads_checked++;
		end
	end

	// Every DRAM write must carry the latest value of its address.
	always @(negedge clk)
	begin
		if (rst && dram_cs && dram_ack)
		begin
			dram_log.push_back({dram_we, dram_addr});
			if (dram_we)
			begin
				assert (dram_wdata === shadow[dram_addr])
				else flag_mismatch("dram_wdata", dram_wdata, shadow[dram_addr]);
			end
		end
	end

	// Each operation gets 20 cycles, plus slack for reset.
	initial
	begin
		repeat (num_ops * 20 + 50) @(posedge clk);
		fail_run("Timeout, the cache stopped answering requests.");
	end

	initial
	begin
		int          cycles;
		int          log_size;
		addr_t       addr_a;
		addr_t       addr_b;
		data_t       wdata;
		logic [31:0] r;
		rst = 1'b0;
		cpu_cs = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		latency = 3'd0;
		rng_state = 32'hc9a2;
		for (int a = 0; a < (1 << addr_w); a++)
			shadow[a] = preload_word(a);
		repeat (4) @(posedge clk);
		#drive_delay;
		rst = 1'b1;

		// Quiet after reset.
		repeat (3)
		begin
			@(negedge clk);
			assert (!cpu_ack && !dram_cs)
			else fail_run("cpu_ack or dram_cs went high with no request.");
		end

		// First read of A is a miss and fetches the preload.
		addr_a = {8'h12, 6'h05};
		addr_b = {8'h34, 6'h05};
		log_size = dram_log.size();
		cpu_access(1'b0, addr_a, '0, 3'd2, cycles);
		assert (dram_log.size() == log_size + 1 && dram_log[log_size] == {1'b0, addr_a})
		else fail_run("The first read of an address did not fetch it from DRAM.");

		// Write hit, then a read hit with no DRAM traffic.
		wdata = 32'h1357_9bdf;
		cpu_access(1'b1, addr_a, wdata, 3'd1, cycles);
		assert (cycles == 3)
		else fail_run("A write hit did not acknowledge two cycles after it was sampled.");
		log_size = dram_log.size();
		cpu_access(1'b0, addr_a, '0, 3'd1, cycles);
		assert (dram_log.size() == log_size)
		else fail_run("A read hit went out to DRAM.");
		assert (cycles == 2)
		else fail_run("A read hit did not acknowledge one cycle after it was sampled.");

		// A read of B on the same index writes the dirty A back before the fill.
		log_size = dram_log.size();
		cpu_access(1'b0, addr_b, '0, 3'd3, cycles);
		assert (dram_log.size() == log_size + 2 && dram_log[log_size] == {1'b1, addr_a}
			&& dram_log[log_size + 1] == {1'b0, addr_b})
		else fail_run("A dirty victim was not written back before the fill.");

		// Four tags over four lines, so conflicts are frequent.
		for (int i = 0; i < num_random; i++)
		begin
			rng_state = xorshift(rng_state);
			r = rng_state;
			addr_a = {r[3:2], 6'h15, 4'h0, r[1:0]};
			rng_state = xorshift(rng_state);
			wdata = rng_state;
			rng_state = xorshift(rng_state);
			cpu_access(r[5], addr_a, wdata, 3'(rng_state % 6), cycles);
		end

		if (reads_checked < num_random / 4)
			fail_run("Too few reads were checked against the reference.");
		else
		begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/cache_pkg.sv
hdl/cache_controller.sv
hdl/cache_tag_store.sv
hdl/cache_data_store.sv
hdl/l1_cache.sv
tests/dram_model.sv
tests/l1_cache_tb.sv

// ==== Makefile ====
TOP = l1_cache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
